// ==== core_macros.svh ====
// core-wide constants: widths, opcodes, CSR addresses, trap cause and vector

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// widths
`define XLEN        32
`define REG_ADDR_W  5
`define CSR_ADDR_W  12

// machine CSRs
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// trap handling
`define CAUSE_ILLEGAL 32'd2
`define TRAP_VECTOR   32'h0000_0200

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_SYSTEM  7'b1110011

`endif

// ==== core_pkg.sv ====
// shared pipeline types: operation enum, exception,
// fetch entry, decoded instruction and EX result
`default_nettype none
`include "core_macros.svh"

package core_pkg;

  // OP_ILLEGAL marks an encoding outside the supported subset
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_LUI,
    OP_BEQ,
    OP_BNE,
    OP_JAL,
    OP_CSRRW,
    OP_MRET,
    OP_ILLEGAL
  } fu_op_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] cause;
  } exception_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      instr;
  } fetch_entry_t;

  // operands are already resolved through the bypass network
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    fu_op_t                 op;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rf_we;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;
    logic [`XLEN-1:0]       imm;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    exception_t             ex;
  } decoded_t;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rf_we;
    logic [`XLEN-1:0]       result;
    logic                   mret;
    logic                   csr_we;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       csr_wdata;
    exception_t             ex;
  } result_t;

endpackage

`default_nettype wire

// ==== frontend.sv ====
// instruction fetch: PC register, request to the instruction port,
// pairing of the response with its address into the fetch entry
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module frontend (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`XLEN-1:0]       boot_addr_i,
  input  logic                   branch_redirect_i,
  input  logic [`XLEN-1:0]       branch_target_i,
  input  logic                   commit_redirect_i,
  input  logic [`XLEN-1:0]       commit_target_i,
  output logic                   imem_req_o,
  output logic [`XLEN-1:0]       imem_addr_o,
  input  logic [31:0]            imem_rdata_i,
  output core_pkg::fetch_entry_t fetch_entry_o,
  output logic                   fetch_valid_o
);

  logic             started_q;
  logic [`XLEN-1:0] pc_q;
  logic             pending_q;
  logic [`XLEN-1:0] pending_pc_q;
  logic             redirect;

  assign redirect   = commit_redirect_i | branch_redirect_i;
  assign imem_req_o = started_q;

  // commit redirect is older than the branch in EX
  always_comb begin
    if (commit_redirect_i) begin
      imem_addr_o = commit_target_i;
    end else if (branch_redirect_i) begin
      imem_addr_o = branch_target_i;
    end else begin
      imem_addr_o = pc_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q     <= 1'b0;
      pc_q          <= '0;
      pending_q     <= 1'b0;
      fetch_valid_o <= 1'b0;
    end else begin
      started_q     <= 1'b1;
      // first cycle out of reset only loads the boot address
      pc_q          <= started_q ? imem_addr_o + `XLEN'd4 : boot_addr_i;
      pending_q     <= imem_req_o;
      // response to a wrong-path request is dropped
      fetch_valid_o <= pending_q & ~redirect;
    end
  end

  always_ff @(posedge clk_i) begin
    pending_pc_q        <= imem_addr_o;
    fetch_entry_o.pc    <= pending_pc_q;
    fetch_entry_o.instr <= imem_rdata_i;
  end

  // targets from EX and commit must stay word aligned
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_req_o |-> imem_addr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== id_stage.sv ====
// decode stage: decoder, illegal-instruction check, operand bypass
// and the ID/EX pipeline register
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module id_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  core_pkg::fetch_entry_t fetch_entry_i,
  input  logic                   fetch_valid_i,
  output logic [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  input  logic                   ex_fwd_we_i,
  input  logic [`REG_ADDR_W-1:0] ex_fwd_addr_i,
  input  logic [`XLEN-1:0]       ex_fwd_data_i,
  input  logic                   wb_we_i,
  input  logic [`REG_ADDR_W-1:0] wb_addr_i,
  input  logic [`XLEN-1:0]       wb_data_i,
  output core_pkg::decoded_t     decoded_o,
  output logic                   decoded_valid_o
);

  logic [31:0]        instr;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [`XLEN-1:0]   imm_i;
  logic [`XLEN-1:0]   imm_u;
  logic [`XLEN-1:0]   imm_b;
  logic [`XLEN-1:0]   imm_j;
  logic               legal;
  core_pkg::decoded_t dec;

  // EX result first, then the write in commit, then the register file
  function automatic logic [`XLEN-1:0] operand(input logic [`REG_ADDR_W-1:0] addr,
                                               input logic [`XLEN-1:0]       rf_data);
    logic [`XLEN-1:0] data;
    data = rf_data;
    if (addr == '0) begin
      data = '0;
    end else if (ex_fwd_we_i && ex_fwd_addr_i == addr) begin
      data = ex_fwd_data_i;
    end else if (wb_we_i && wb_addr_i == addr) begin
      data = wb_data_i;
    end
    return data;
  endfunction

  assign instr      = fetch_entry_i.instr;
  assign opcode     = instr[6:0];
  assign funct3     = instr[14:12];
  assign funct7     = instr[31:25];
  assign rs1_addr_o = instr[19:15];
  assign rs2_addr_o = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // legal words of the supported subset, decoded apart from the op select
  always_comb begin
    case (opcode)
      `OPC_OP: begin
        legal = (funct7 == 7'b0000000 &&
                 funct3 inside {3'b000, 3'b100, 3'b110, 3'b111}) ||
                (funct7 == 7'b0100000 && funct3 == 3'b000);
      end
      `OPC_OP_IMM: legal = (funct3 == 3'b000);
      `OPC_LUI:    legal = 1'b1;
      `OPC_BRANCH: legal = (funct3 == 3'b000 || funct3 == 3'b001);
      `OPC_JAL:    legal = 1'b1;
      `OPC_SYSTEM: begin
        legal = (instr == 32'h3020_0073) ||
                (funct3 == 3'b001 &&
                 (instr[31:20] == `CSR_MEPC || instr[31:20] == `CSR_MCAUSE));
      end
      default:     legal = 1'b0;
    endcase
  end

  always_comb begin
    dec          = '0;
    dec.pc       = fetch_entry_i.pc;
    dec.rd       = instr[11:7];
    dec.op_a     = operand(rs1_addr_o, rs1_data_i);
    dec.op_b     = operand(rs2_addr_o, rs2_data_i);
    dec.imm      = imm_i;
    dec.csr_addr = instr[31:20];
    dec.op       = core_pkg::OP_ILLEGAL;
    case (opcode)
      `OPC_OP: begin
        dec.rf_we = 1'b1;
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  dec.op = core_pkg::OP_ADD;
            3'b100:  dec.op = core_pkg::OP_XOR;
            3'b110:  dec.op = core_pkg::OP_OR;
            3'b111:  dec.op = core_pkg::OP_AND;
            default: dec.op = core_pkg::OP_ILLEGAL;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec.op = core_pkg::OP_SUB;
        end
      end
      `OPC_OP_IMM: begin
        // only ADDI
        if (funct3 == 3'b000) begin
          dec.op    = core_pkg::OP_ADD;
          dec.op_b  = imm_i;
          dec.rf_we = 1'b1;
        end
      end
      `OPC_LUI: begin
        dec.op    = core_pkg::OP_LUI;
        dec.imm   = imm_u;
        dec.rf_we = 1'b1;
      end
      `OPC_BRANCH: begin
        dec.imm = imm_b;
        if (funct3 == 3'b000) begin
          dec.op = core_pkg::OP_BEQ;
        end else if (funct3 == 3'b001) begin
          dec.op = core_pkg::OP_BNE;
        end
      end
      `OPC_JAL: begin
        dec.op    = core_pkg::OP_JAL;
        dec.imm   = imm_j;
        dec.rf_we = 1'b1;
      end
      `OPC_SYSTEM: begin
        if (instr == 32'h3020_0073) begin
          dec.op = core_pkg::OP_MRET;
        end else if (funct3 == 3'b001 &&
                     (dec.csr_addr == `CSR_MEPC || dec.csr_addr == `CSR_MCAUSE)) begin
          dec.op    = core_pkg::OP_CSRRW;
          dec.rf_we = 1'b1;
        end
      end
      default: dec.op = core_pkg::OP_ILLEGAL;
    endcase
    if (!legal) begin
      dec.rf_we    = 1'b0;
      dec.ex.valid = 1'b1;
      dec.ex.cause = `CAUSE_ILLEGAL;
    end
    if (dec.rd == '0) begin
      dec.rf_we = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      decoded_valid_o <= 1'b0;
    end else begin
      decoded_valid_o <= fetch_valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    decoded_o <= dec;
  end

  // an unsupported word always reaches EX flagged as a trap
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    decoded_valid_o && decoded_o.op == core_pkg::OP_ILLEGAL |-> decoded_o.ex.valid);

endmodule

`default_nettype wire

// ==== regfile.sv ====
// integer register file, two read ports and one write port
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module regfile (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`REG_ADDR_W-1:0] raddr_b_i,
  output logic [`XLEN-1:0]       rdata_a_o,
  output logic [`XLEN-1:0]       rdata_b_o,
  input  logic                   we_i,
  input  logic [`REG_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]       wdata_i
);

  // x0 has no storage
  logic [`XLEN-1:0] regs_q [31:1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
// execute stage: ALU, branch and jump resolution, CSR read
// and the EX/commit pipeline register
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module ex_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  core_pkg::decoded_t     decoded_i,
  input  logic                   decoded_valid_i,
  output logic [`CSR_ADDR_W-1:0] csr_raddr_o,
  input  logic [`XLEN-1:0]       csr_rdata_i,
  output logic                   ex_fwd_we_o,
  output logic [`REG_ADDR_W-1:0] ex_fwd_addr_o,
  output logic [`XLEN-1:0]       ex_fwd_data_o,
  output logic                   branch_redirect_o,
  output logic [`XLEN-1:0]       branch_target_o,
  output core_pkg::result_t      result_o,
  output logic                   result_valid_o
);

  logic [`XLEN-1:0] alu_res;
  logic             taken;
  logic             live;

  // a valid instruction that has not trapped in decode
  assign live = decoded_valid_i & ~decoded_i.ex.valid;

  always_comb begin
    alu_res = '0;
    taken   = 1'b0;
    case (decoded_i.op)
      core_pkg::OP_ADD:   alu_res = decoded_i.op_a + decoded_i.op_b;
      core_pkg::OP_SUB:   alu_res = decoded_i.op_a - decoded_i.op_b;
      core_pkg::OP_AND:   alu_res = decoded_i.op_a & decoded_i.op_b;
      core_pkg::OP_OR:    alu_res = decoded_i.op_a | decoded_i.op_b;
      core_pkg::OP_XOR:   alu_res = decoded_i.op_a ^ decoded_i.op_b;
      core_pkg::OP_LUI:   alu_res = decoded_i.imm;
      core_pkg::OP_BEQ:   taken = (decoded_i.op_a == decoded_i.op_b);
      core_pkg::OP_BNE:   taken = (decoded_i.op_a != decoded_i.op_b);
      core_pkg::OP_CSRRW: alu_res = csr_rdata_i;
      core_pkg::OP_JAL: begin
        alu_res = decoded_i.pc + `XLEN'd4;
        taken   = 1'b1;
      end
      default: alu_res = '0;
    endcase
  end

  assign csr_raddr_o       = decoded_i.csr_addr;
  assign branch_target_o   = decoded_i.pc + decoded_i.imm;
  assign branch_redirect_o = live & taken & ~flush_i;

  // bypass towards the instruction now in decode
  assign ex_fwd_we_o   = live & decoded_i.rf_we;
  assign ex_fwd_addr_o = decoded_i.rd;
  assign ex_fwd_data_o = alu_res;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= decoded_valid_i & ~flush_i;
    end
  end

  always_ff @(posedge clk_i) begin
    result_o.pc        <= decoded_i.pc;
    result_o.rd        <= decoded_i.rd;
    result_o.rf_we     <= decoded_i.rf_we;
    result_o.result    <= alu_res;
    result_o.mret      <= (decoded_i.op == core_pkg::OP_MRET);
    result_o.csr_we    <= (decoded_i.op == core_pkg::OP_CSRRW);
    result_o.csr_addr  <= decoded_i.csr_addr;
    result_o.csr_wdata <= decoded_i.op_a;
    result_o.ex        <= decoded_i.ex;
  end

endmodule

`default_nettype wire

// ==== commit_stage.sv ====
// commit stage: retirement, write-back, trap and MRET redirect,
// pipeline flush and the retired-instruction port
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module commit_stage (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  core_pkg::result_t      result_i,
  input  logic                   result_valid_i,
  input  logic [`XLEN-1:0]       mepc_i,
  output logic                   wb_we_o,
  output logic [`REG_ADDR_W-1:0] wb_addr_o,
  output logic [`XLEN-1:0]       wb_data_o,
  output logic                   csr_we_o,
  output logic [`CSR_ADDR_W-1:0] csr_waddr_o,
  output logic [`XLEN-1:0]       csr_wdata_o,
  output logic                   trap_save_o,
  output logic [`XLEN-1:0]       trap_pc_o,
  output logic [`XLEN-1:0]       trap_cause_o,
  output logic                   commit_redirect_o,
  output logic [`XLEN-1:0]       commit_target_o,
  output logic                   commit_valid_o,
  output logic [`XLEN-1:0]       commit_pc_o,
  output logic                   commit_we_o,
  output logic [`REG_ADDR_W-1:0] commit_waddr_o,
  output logic [`XLEN-1:0]       commit_wdata_o,
  output logic                   commit_ex_o,
  output logic [`XLEN-1:0]       commit_cause_o
);

  logic trap;
  logic mret;

  assign trap = result_valid_i & result_i.ex.valid;
  assign mret = result_valid_i & ~result_i.ex.valid & result_i.mret;

  // architectural writes, suppressed on a trap
  assign wb_we_o     = result_valid_i & ~result_i.ex.valid & result_i.rf_we;
  assign wb_addr_o   = result_i.rd;
  assign wb_data_o   = result_i.result;
  assign csr_we_o    = result_valid_i & ~result_i.ex.valid & result_i.csr_we;
  assign csr_waddr_o = result_i.csr_addr;
  assign csr_wdata_o = result_i.csr_wdata;

  assign trap_save_o  = trap;
  assign trap_pc_o    = result_i.pc;
  assign trap_cause_o = result_i.ex.cause;

  // flushes everything younger and refetches
  assign commit_redirect_o = trap | mret;
  assign commit_target_o   = trap ? `TRAP_VECTOR : mepc_i;

  assign commit_valid_o = result_valid_i;
  assign commit_pc_o    = result_i.pc;
  // write flag as carried down the pipe
  assign commit_we_o    = result_valid_i & result_i.rf_we;
  assign commit_waddr_o = result_i.rd;
  assign commit_wdata_o = result_i.result;
  assign commit_ex_o    = trap;
  assign commit_cause_o = result_i.ex.cause;

  // a trapping instruction never writes the register file
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(commit_we_o && commit_ex_o));

endmodule

`default_nettype wire

// ==== csr_regfile.sv ====
// machine CSRs mepc and mcause with write-through read
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module csr_regfile (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`CSR_ADDR_W-1:0] raddr_i,
  output logic [`XLEN-1:0]       rdata_o,
  input  logic                   we_i,
  input  logic [`CSR_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]       wdata_i,
  input  logic                   trap_save_i,
  input  logic [`XLEN-1:0]       trap_pc_i,
  input  logic [`XLEN-1:0]       trap_cause_i,
  output logic [`XLEN-1:0]       mepc_o
);

  logic [`XLEN-1:0] mepc_q, mepc_d;
  logic [`XLEN-1:0] mcause_q, mcause_d;

  // trap entry wins over a CSR write
  always_comb begin
    mepc_d   = mepc_q;
    mcause_d = mcause_q;
    if (trap_save_i) begin
      mepc_d   = trap_pc_i;
      mcause_d = trap_cause_i;
    end else if (we_i) begin
      if (waddr_i == `CSR_MEPC) begin
        mepc_d = wdata_i;
      end else if (waddr_i == `CSR_MCAUSE) begin
        mcause_d = wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mepc_q   <= mepc_d;
      mcause_q <= mcause_d;
    end
  end

  // EX sees the value commit is writing this cycle
  assign rdata_o = (raddr_i == `CSR_MEPC)   ? mepc_d :
                   (raddr_i == `CSR_MCAUSE) ? mcause_d : '0;
  assign mepc_o  = mepc_q;

endmodule

`default_nettype wire

// ==== core_top.sv ====
// core top level: frontend, decode, register file, execute,
// commit and CSR file wired together
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module core_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`XLEN-1:0]       boot_addr_i,
  output logic                   imem_req_o,
  output logic [`XLEN-1:0]       imem_addr_o,
  input  logic [31:0]            imem_rdata_i,
  output logic                   commit_valid_o,
  output logic [`XLEN-1:0]       commit_pc_o,
  output logic                   commit_we_o,
  output logic [`REG_ADDR_W-1:0] commit_waddr_o,
  output logic [`XLEN-1:0]       commit_wdata_o,
  output logic                   commit_ex_o,
  output logic [`XLEN-1:0]       commit_cause_o
);

  // --------------------------------------------------------------------------
  // inter-stage wires
  // --------------------------------------------------------------------------
  core_pkg::fetch_entry_t fetch_entry;
  logic                   fetch_valid;
  core_pkg::decoded_t     decoded;
  logic                   decoded_valid;
  core_pkg::result_t      result;
  logic                   result_valid;

  logic [`REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [`XLEN-1:0]       rs1_data, rs2_data;
  logic                   ex_fwd_we;
  logic [`REG_ADDR_W-1:0] ex_fwd_addr;
  logic [`XLEN-1:0]       ex_fwd_data;
  logic                   wb_we;
  logic [`REG_ADDR_W-1:0] wb_addr;
  logic [`XLEN-1:0]       wb_data;

  logic                   branch_redirect, commit_redirect;
  logic [`XLEN-1:0]       branch_target, commit_target;

  logic [`CSR_ADDR_W-1:0] csr_raddr, csr_waddr;
  logic [`XLEN-1:0]       csr_rdata, csr_wdata;
  logic                   csr_we;
  logic                   trap_save;
  logic [`XLEN-1:0]       trap_pc, trap_cause, mepc;

  // decode is flushed by either redirect
  wire                    flush_id = branch_redirect | commit_redirect;

  frontend i_frontend (
    .clk_i, .rst_ni, .boot_addr_i,
    .branch_redirect_i ( branch_redirect ),
    .branch_target_i   ( branch_target   ),
    .commit_redirect_i ( commit_redirect ),
    .commit_target_i   ( commit_target   ),
    .imem_req_o, .imem_addr_o, .imem_rdata_i,
    .fetch_entry_o     ( fetch_entry     ),
    .fetch_valid_o     ( fetch_valid     )
  );

  id_stage i_id_stage (
    .clk_i, .rst_ni,
    .flush_i         ( flush_id      ),
    .fetch_entry_i   ( fetch_entry   ),
    .fetch_valid_i   ( fetch_valid   ),
    .rs1_addr_o      ( rs1_addr      ),
    .rs2_addr_o      ( rs2_addr      ),
    .rs1_data_i      ( rs1_data      ),
    .rs2_data_i      ( rs2_data      ),
    .ex_fwd_we_i     ( ex_fwd_we     ),
    .ex_fwd_addr_i   ( ex_fwd_addr   ),
    .ex_fwd_data_i   ( ex_fwd_data   ),
    .wb_we_i         ( wb_we         ),
    .wb_addr_i       ( wb_addr       ),
    .wb_data_i       ( wb_data       ),
    .decoded_o       ( decoded       ),
    .decoded_valid_o ( decoded_valid )
  );

  regfile i_regfile (
    .clk_i, .rst_ni,
    .raddr_a_i ( rs1_addr ),
    .raddr_b_i ( rs2_addr ),
    .rdata_a_o ( rs1_data ),
    .rdata_b_o ( rs2_data ),
    .we_i      ( wb_we    ),
    .waddr_i   ( wb_addr  ),
    .wdata_i   ( wb_data  )
  );

  ex_stage i_ex_stage (
    .clk_i, .rst_ni,
    .flush_i           ( commit_redirect ),
    .decoded_i         ( decoded         ),
    .decoded_valid_i   ( decoded_valid   ),
    .csr_raddr_o       ( csr_raddr       ),
    .csr_rdata_i       ( csr_rdata       ),
    .ex_fwd_we_o       ( ex_fwd_we       ),
    .ex_fwd_addr_o     ( ex_fwd_addr     ),
    .ex_fwd_data_o     ( ex_fwd_data     ),
    .branch_redirect_o ( branch_redirect ),
    .branch_target_o   ( branch_target   ),
    .result_o          ( result          ),
    .result_valid_o    ( result_valid    )
  );

  commit_stage i_commit_stage (
    .clk_i, .rst_ni,
    .result_i          ( result          ),
    .result_valid_i    ( result_valid    ),
    .mepc_i            ( mepc            ),
    .wb_we_o           ( wb_we           ),
    .wb_addr_o         ( wb_addr         ),
    .wb_data_o         ( wb_data         ),
    .csr_we_o          ( csr_we          ),
    .csr_waddr_o       ( csr_waddr       ),
    .csr_wdata_o       ( csr_wdata       ),
    .trap_save_o       ( trap_save       ),
    .trap_pc_o         ( trap_pc         ),
    .trap_cause_o      ( trap_cause      ),
    .commit_redirect_o ( commit_redirect ),
    .commit_target_o   ( commit_target   ),
    .commit_valid_o, .commit_pc_o, .commit_we_o, .commit_waddr_o,
    .commit_wdata_o, .commit_ex_o, .commit_cause_o
  );

  csr_regfile i_csr_regfile (
    .clk_i, .rst_ni,
    .raddr_i      ( csr_raddr  ),
    .rdata_o      ( csr_rdata  ),
    .we_i         ( csr_we     ),
    .waddr_i      ( csr_waddr  ),
    .wdata_i      ( csr_wdata  ),
    .trap_save_i  ( trap_save  ),
    .trap_pc_i    ( trap_pc    ),
    .trap_cause_i ( trap_cause ),
    .mepc_o       ( mepc       )
  );

endmodule

`default_nettype wire

// ==== tb_core.sv ====
// testbench for core_top: instruction memory model, golden retirement
// stream compare, timeout and final report
`timescale 1ns/10ps
`default_nettype none
`include "core_macros.svh"

module tb_core;

  localparam int IMEM_WORDS   = 256;
  localparam int GOLDEN_WORDS = 512;
  localparam int MAX_TESTS    = 8;

  logic                   clk_i;
  logic                   rst_ni;
  logic [`XLEN-1:0]       boot_addr_i;
  logic                   imem_req_o;
  logic [`XLEN-1:0]       imem_addr_o;
  logic [31:0]            imem_rdata_i;
  logic                   commit_valid_o;
  logic [`XLEN-1:0]       commit_pc_o;
  logic                   commit_we_o;
  logic [`REG_ADDR_W-1:0] commit_waddr_o;
  logic [`XLEN-1:0]       commit_wdata_o;
  logic                   commit_ex_o;
  logic [`XLEN-1:0]       commit_cause_o;

  logic [31:0] imem   [0:IMEM_WORDS-1];
  logic [31:0] golden [0:GOLDEN_WORDS-1];

  int               n_prog;
  int               n_tests;
  int               n_records;
  int               rec_base;
  int               test_len [0:MAX_TESTS-1];
  int               rec_idx;
  int               cur_test;
  int               rec_in_test;
  int               errors;
  int               test_errors;
  int               cycles;
  int               limit;
  logic             timed_out;
  logic [`XLEN-1:0] cur_pc;
  logic             fetch_req;
  logic [`XLEN-1:0] fetch_addr;

  core_top DUT (
    .clk_i, .rst_ni, .boot_addr_i,
    .imem_req_o, .imem_addr_o, .imem_rdata_i,
    .commit_valid_o, .commit_pc_o, .commit_we_o, .commit_waddr_o,
    .commit_wdata_o, .commit_ex_o, .commit_cause_o
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // instruction memory
  // --------------------------------------------------------------------------

  // low two bits stay 00, so an unloaded word decodes as illegal
  function automatic logic [31:0] fill_word(input logic [`XLEN-1:0] addr);
    return addr ^ 32'hdead_bee0;
  endfunction

  function automatic logic [31:0] mem_word(input logic [`XLEN-1:0] addr);
    logic [31:0] data;
    if (addr[`XLEN-1:10] == '0) begin
      data = imem[addr[9:2]];
    end else begin
      data = fill_word(addr);
    end
    return data;
  endfunction

  // request is stable around the falling edge
  always @(negedge clk_i) begin
    fetch_req  <= imem_req_o;
    fetch_addr <= imem_addr_o;
  end

  always @(posedge clk_i) begin
    #1;
    imem_rdata_i = fetch_req ? mem_word(fetch_addr) : '0;
  end

  // --------------------------------------------------------------------------
  // golden file and compares
  // --------------------------------------------------------------------------

  function automatic string test_name(input int idx);
    case (idx)
      0:       return "ALU and LUI chains";
      1:       return "writes to x0";
      2:       return "branches and JAL";
      3:       return "illegal instruction trap";
      4:       return "trap handler and MRET";
      default: return "unnamed";
    endcase
  endfunction

  task automatic load_golden();
    int base;
    int t;
    int i;
    $readmemh("core_golden.hex", golden);
    n_records = 0;
    if ($isunknown(golden[0]) || $isunknown(golden[1]) || golden[1] > MAX_TESTS) begin
      $display("core_golden.hex could not be read or its header is not valid");
      errors++;
    end else begin
      n_prog  = golden[0];
      n_tests = golden[1];
      for (t = 0; t < n_tests; t++) begin
        test_len[t] = golden[2 + t];
        n_records   = n_records + test_len[t];
      end
      base     = 2 + n_tests;
      rec_base = base + 2 * n_prog;
      for (i = 0; i < n_prog; i++) begin
        imem[golden[base + 2 * i][9:2]] = golden[base + 2 * i + 1];
      end
    end
  endtask

  task automatic check_word(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s at pc 0x%h: got 0x%h, expected 0x%h", name, cur_pc, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_reg(input string name, input logic [`REG_ADDR_W-1:0] got,
                           input logic [`REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s at pc 0x%h: got 0x%h, expected 0x%h", name, cur_pc, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s at pc 0x%h: got 0x%h, expected 0x%h", name, cur_pc, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  // waddr and wdata only matter on a write, cause only on a trap
  task automatic check_retirement();
    int b;
    b      = rec_base + 6 * rec_idx;
    cur_pc = golden[b];
    check_word("commit_pc_o", commit_pc_o, golden[b]);
    check_bit("commit_we_o", commit_we_o, golden[b + 1][0]);
    if (golden[b + 1][0]) begin
      check_reg("commit_waddr_o", commit_waddr_o, golden[b + 2][`REG_ADDR_W-1:0]);
      check_word("commit_wdata_o", commit_wdata_o, golden[b + 3]);
    end
    check_bit("commit_ex_o", commit_ex_o, golden[b + 4][0]);
    if (golden[b + 4][0]) begin
      check_word("commit_cause_o", commit_cause_o, golden[b + 5]);
    end
    rec_idx++;
    rec_in_test++;
    if (rec_in_test == test_len[cur_test]) begin
      if (test_errors == 0) begin
        $display("test %0d, %s: %0d retirements ok", cur_test + 1, test_name(cur_test),
                 rec_in_test);
      end else begin
        $display("test %0d, %s: %0d mismatches", cur_test + 1, test_name(cur_test),
                 test_errors);
      end
      cur_test++;
      rec_in_test = 0;
      test_errors = 0;
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin : main_seq
    int i;
    rst_ni       = 1'b0;
    boot_addr_i  = '0;
    imem_rdata_i = '0;
    fetch_req    = 1'b0;
    fetch_addr   = '0;
    errors       = 0;
    test_errors  = 0;
    rec_idx      = 0;
    cur_test     = 0;
    rec_in_test  = 0;
    cycles       = 0;
    n_records    = 0;
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = fill_word(i * 4);
    end
    load_golden();
    // worst case is a trap bubble on every record
    limit = 8 * n_records + 100;

    repeat (4) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    while (rec_idx < n_records && cycles < limit) begin
      @(negedge clk_i);
      cycles++;
      if (commit_valid_o) begin
        check_retirement();
      end
    end

    timed_out = (rec_idx < n_records);
    if (timed_out) begin
      $display("timeout after %0d cycles: %0d of %0d expected retirements never seen",
               cycles, n_records - rec_idx, n_records);
    end
    $display("%0d tests done, %0d retirements checked, %0d errors", cur_test, rec_idx,
             errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== core_golden.hex ====
// header: program word count, test count, then retirements per test
// program: address instruction; records: pc we waddr wdata ex cause
00000021 00000005
00000009 00000004 00000006 00000001 00000008
// program at boot address 0
00000000 00500093
00000004 00708113
00000008 002081b3
0000000c 40118233
00000010 123452b7
00000014 0032c333
00000018 002363b3
0000001c 0053f433
00000020 fff40493
00000024 06308013
00000028 00100533
0000002c abcde037
00000030 00300593
00000034 00a08663
00000038 00100613
0000003c 00200613
00000040 00209463
00000044 00300613
00000048 00c006ef
0000004c 00400613
00000050 00500613
00000054 00168733
00000058 00208463
0000005c 00170793
00000060 300092f3
00000064 02888a13
00000068 0000006f
// trap handler
00000200 34101873
00000204 342018f3
00000208 00480913
0000020c 341919f3
00000210 30200073
00000214 00600613
// ALU and LUI chains
00000000 1 01 00000005 0 00000000
00000004 1 02 0000000c 0 00000000
00000008 1 03 00000011 0 00000000
0000000c 1 04 0000000c 0 00000000
00000010 1 05 12345000 0 00000000
00000014 1 06 12345011 0 00000000
00000018 1 07 1234501d 0 00000000
0000001c 1 08 12345000 0 00000000
00000020 1 09 12344fff 0 00000000
// writes to x0
00000024 0 00 00000000 0 00000000
00000028 1 0a 00000005 0 00000000
0000002c 0 00 00000000 0 00000000
00000030 1 0b 00000003 0 00000000
// branches and JAL
00000034 0 00 00000000 0 00000000
00000040 0 00 00000000 0 00000000
00000048 1 0d 0000004c 0 00000000
00000054 1 0e 00000051 0 00000000
00000058 0 00 00000000 0 00000000
0000005c 1 0f 00000052 0 00000000
// illegal instruction
00000060 0 00 00000000 1 00000002
// handler, MRET and resume
00000200 1 10 00000060 0 00000000
00000204 1 11 00000002 0 00000000
00000208 1 12 00000064 0 00000000
0000020c 1 13 00000000 0 00000000
00000210 0 00 00000000 0 00000000
00000064 1 14 0000002a 0 00000000
00000068 0 00 00000000 0 00000000
00000068 0 00 00000000 0 00000000

// ==== all.f ====
+incdir+.
core_pkg.sv
frontend.sv
id_stage.sv
regfile.sv
ex_stage.sv
commit_stage.sv
csr_regfile.sv
core_top.sv
tb_core.sv

// ==== Makefile ====
# Verilator simulation of the core testbench

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
